/* proc_ci_pkg.sv */
package proc_ci_pkg;

    localparam int BUS_WIDTH = 32;

    // Host opcodes
    localparam logic [7:0] CMD_WRITE     = 8'h01;
    localparam logic [7:0] CMD_READ      = 8'h02;
    localparam logic [7:0] CMD_RUN       = 8'h03;
    localparam logic [7:0] CMD_HALT_CORE = 8'h04;

    // Reply bytes
    localparam logic [7:0] RSP_OK   = 8'hAA;
    localparam logic [7:0] RSP_DONE = 8'h55;
    localparam logic [7:0] RSP_BAD  = 8'hEE;

    // RV32I major opcodes
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    // One instruction word, two field layouts
    typedef union packed {
        struct packed {
            logic [6:0] funct7;      // Also imm[11:5] for I-type
            logic [4:0] rs2;         // Also imm[4:0] for I-type
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } ri;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } sb;
    } instr_t;

endpackage

/* uart_rx.sv */
`timescale 1ns/1ns

module uart_rx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic       sys_clk_i,
    input  logic       reset_i,
    input  logic       rx_i,
    output logic [7:0] rx_data_o,
    output logic       rx_valid_o
);

    localparam int CW = $clog2(CLKS_PER_BIT + 1);
    localparam logic [CW-1:0] LAST = CW'(CLKS_PER_BIT - 1);
    // Two sync flops already eat part of the half bit
    localparam logic [CW-1:0] HALF = CW'((CLKS_PER_BIT >= 4) ? CLKS_PER_BIT / 2 - 2 : 0);

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_START = 2'd1;
    localparam logic [1:0] S_DATA  = 2'd2;
    localparam logic [1:0] S_STOP  = 2'd3;

    logic [1:0]    rx_sync_q;
    logic [1:0]    state_q;
    logic [CW-1:0] clk_cnt_q;
    logic [2:0]    bit_idx_q;

    always_ff @(posedge sys_clk_i) begin
        if (reset_i) begin
            rx_sync_q  <= 2'b11;    // Line idles high
            state_q    <= S_IDLE;
            clk_cnt_q  <= '0;
            bit_idx_q  <= '0;
            rx_valid_o <= 1'b0;
        end else begin
            rx_sync_q  <= {rx_sync_q[0], rx_i};
            rx_valid_o <= 1'b0;
            clk_cnt_q  <= clk_cnt_q + 1'b1;
            case (state_q)
                S_IDLE: begin
                    clk_cnt_q <= '0;
                    if (!rx_sync_q[1])
                        state_q <= S_START;
                end
                S_START: if (clk_cnt_q == HALF) begin
                    clk_cnt_q <= '0;
                    bit_idx_q <= '0;
                    state_q   <= rx_sync_q[1] ? S_IDLE : S_DATA;   // Glitch, not a start bit
                end
                S_DATA: if (clk_cnt_q == LAST) begin
                    clk_cnt_q <= '0;
                    rx_data_o <= {rx_sync_q[1], rx_data_o[7:1]};    // LSB first
                    bit_idx_q <= bit_idx_q + 1'b1;
                    if (bit_idx_q == 3'd7)
                        state_q <= S_STOP;
                end
                default: if (clk_cnt_q == LAST) begin
                    rx_valid_o <= rx_sync_q[1];    // Framing error drops the byte
                    state_q    <= S_IDLE;
                end
            endcase
        end
    end

endmodule

/* uart_tx.sv */
`timescale 1ns/1ns

module uart_tx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic       sys_clk_i,
    input  logic       reset_i,
    input  logic [7:0] tx_data_i,
    input  logic       tx_start_i,
    output logic       tx_o,
    output logic       tx_busy_o
);

    localparam int CW = $clog2(CLKS_PER_BIT + 1);
    localparam logic [CW-1:0] LAST = CW'(CLKS_PER_BIT - 1);

    logic [9:0]    frame_q;    // Stop, data, start
    logic [CW-1:0] clk_cnt_q;
    logic [3:0]    bit_cnt_q;
    logic          busy_q;

    assign tx_o      = frame_q[0];
    assign tx_busy_o = busy_q;

    always_ff @(posedge sys_clk_i) begin
        if (reset_i) begin
            frame_q   <= '1;
            busy_q    <= 1'b0;
            clk_cnt_q <= '0;
            bit_cnt_q <= '0;
        end else if (!busy_q) begin
            if (tx_start_i) begin
                frame_q   <= {1'b1, tx_data_i, 1'b0};
                busy_q    <= 1'b1;
                clk_cnt_q <= '0;
                bit_cnt_q <= '0;
            end
        end else if (clk_cnt_q == LAST) begin
            clk_cnt_q <= '0;
            frame_q   <= {1'b1, frame_q[9:1]};    // Shift in idle level
            if (bit_cnt_q == 4'd9)
                busy_q <= 1'b0;
            else
                bit_cnt_q <= bit_cnt_q + 1'b1;
        end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
        end
    end

endmodule

/* host_cmd_ctrl.sv */
`timescale 1ns/1ns

module host_cmd_ctrl (
    input  logic                              sys_clk_i,
    input  logic                              reset_i,
    input  logic [7:0]                        rx_data_i,
    input  logic                              rx_valid_i,
    output logic [7:0]                        tx_data_o,
    output logic                              tx_start_o,
    input  logic                              tx_busy_i,
    output logic                              bus_cyc_o,
    output logic                              bus_stb_o,
    output logic                              bus_we_o,
    output logic [proc_ci_pkg::BUS_WIDTH-1:0] bus_addr_o,
    output logic [proc_ci_pkg::BUS_WIDTH-1:0] bus_wdata_o,
    input  logic [proc_ci_pkg::BUS_WIDTH-1:0] bus_rdata_i,
    input  logic                              bus_ack_i,
    output logic                              core_run_o,
    input  logic                              core_halted_i
);
    import proc_ci_pkg::*;

    localparam logic [2:0] S_OPC      = 3'd0;
    localparam logic [2:0] S_IDX      = 3'd1;
    localparam logic [2:0] S_DATA     = 3'd2;
    localparam logic [2:0] S_BUS      = 3'd3;
    localparam logic [2:0] S_RUN_GO   = 3'd4;
    localparam logic [2:0] S_RUN_WAIT = 3'd5;
    localparam logic [2:0] S_SEND     = 3'd6;

    logic [2:0]           state_q;
    logic [7:0]           idx_q;
    logic [BUS_WIDTH-1:0] wdata_q;
    logic [BUS_WIDTH-1:0] rsp_q;       // Reply bytes, next one in the low byte
    logic [2:0]           rsp_cnt_q;
    logic [1:0]           byte_cnt_q;
    logic                 we_q;
    logic                 req_q;

    assign bus_cyc_o   = req_q;
    assign bus_stb_o   = req_q;
    assign bus_we_o    = we_q;
    assign bus_addr_o  = {{(BUS_WIDTH - 10){1'b0}}, idx_q, 2'b00};    // Word index to byte address
    assign bus_wdata_o = wdata_q;

    always_ff @(posedge sys_clk_i) begin
        if (reset_i) begin
            state_q    <= S_OPC;
            rsp_cnt_q  <= '0;
            byte_cnt_q <= '0;
            we_q       <= 1'b0;
            req_q      <= 1'b0;
            tx_start_o <= 1'b0;
            core_run_o <= 1'b0;
        end else begin
            tx_start_o <= 1'b0;
            case (state_q)
                S_OPC: if (rx_valid_i) begin
                    we_q <= (rx_data_i == CMD_WRITE);
                    case (rx_data_i)
                        CMD_WRITE, CMD_READ: state_q <= S_IDX;
                        CMD_RUN: state_q <= S_RUN_GO;
                        CMD_HALT_CORE: begin
                            core_run_o <= 1'b0;
                            rsp_q      <= {{(BUS_WIDTH - 8){1'b0}}, RSP_OK};
                            rsp_cnt_q  <= 3'd1;
                            state_q    <= S_SEND;
                        end
                        default: begin
                            rsp_q     <= {{(BUS_WIDTH - 8){1'b0}}, RSP_BAD};
                            rsp_cnt_q <= 3'd1;
                            state_q   <= S_SEND;
                        end
                    endcase
                end
                S_IDX: if (rx_valid_i) begin
                    idx_q      <= rx_data_i;
                    byte_cnt_q <= '0;
                    req_q      <= !we_q;    // Read goes straight to the bus
                    state_q    <= we_q ? S_DATA : S_BUS;
                end
                S_DATA: if (rx_valid_i) begin
                    wdata_q    <= {rx_data_i, wdata_q[BUS_WIDTH-1:8]};
                    byte_cnt_q <= byte_cnt_q + 1'b1;
                    if (byte_cnt_q == 2'd3) begin
                        req_q   <= 1'b1;
                        state_q <= S_BUS;
                    end
                end
                S_BUS: if (bus_ack_i) begin
                    req_q     <= 1'b0;
                    rsp_q     <= we_q ? {{(BUS_WIDTH - 8){1'b0}}, RSP_OK} : bus_rdata_i;
                    rsp_cnt_q <= we_q ? 3'd1 : 3'd4;
                    state_q   <= S_SEND;
                end
                S_RUN_GO: begin
                    core_run_o <= 1'b1;
                    state_q    <= S_RUN_WAIT;
                end
                S_RUN_WAIT: if (core_halted_i) begin
                    rsp_q     <= {{(BUS_WIDTH - 8){1'b0}}, RSP_DONE};
                    rsp_cnt_q <= 3'd1;
                    state_q   <= S_SEND;
                end
                S_SEND: if (!tx_busy_i && !tx_start_o) begin    // Busy rises a cycle after start
                    if (rsp_cnt_q == 3'd0) begin
                        state_q <= S_OPC;
                    end else begin
                        tx_start_o <= 1'b1;
                        tx_data_o  <= rsp_q[7:0];
                        rsp_q      <= rsp_q >> 8;
                        rsp_cnt_q  <= rsp_cnt_q - 3'd1;
                    end
                end
                default: state_q <= S_OPC;
            endcase
        end
    end

endmodule

/* rv_mini_core.sv */
`timescale 1ns/1ns

module rv_mini_core (
    input  logic                              sys_clk_i,
    input  logic                              reset_i,
    input  logic                              core_run_i,
    output logic                              halted_o,
    output logic                              bus_cyc_o,
    output logic                              bus_stb_o,
    output logic                              bus_we_o,
    output logic [proc_ci_pkg::BUS_WIDTH-1:0] bus_addr_o,
    output logic [proc_ci_pkg::BUS_WIDTH-1:0] bus_wdata_o,
    input  logic [proc_ci_pkg::BUS_WIDTH-1:0] bus_rdata_i,
    input  logic                              bus_ack_i
);
    import proc_ci_pkg::*;

    localparam logic [1:0] S_FETCH = 2'd0;
    localparam logic [1:0] S_EXEC  = 2'd1;
    localparam logic [1:0] S_MEM   = 2'd2;
    localparam logic [1:0] S_HALT  = 2'd3;

    logic [1:0]  state_q;
    logic [31:0] pc_q;
    logic [31:0] maddr_q;
    logic [31:0] sdata_q;
    logic        req_q;
    logic        mem_we_q;
    logic        halted_q;
    instr_t      ir_q;
    logic [31:0] regs [1:31];

    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic        rd_nz;

    // x0 reads zero
    assign rs1_val = (ir_q.ri.rs1 == 5'd0) ? 32'd0 : regs[ir_q.ri.rs1];
    assign rs2_val = (ir_q.ri.rs2 == 5'd0) ? 32'd0 : regs[ir_q.ri.rs2];
    assign rd_nz   = (ir_q.ri.rd != 5'd0);

    assign imm_i = {{20{ir_q.ri.funct7[6]}}, ir_q.ri.funct7, ir_q.ri.rs2};
    assign imm_s = {{20{ir_q.sb.imm_hi[6]}}, ir_q.sb.imm_hi, ir_q.sb.imm_lo};
    assign imm_b = {{19{ir_q.sb.imm_hi[6]}}, ir_q.sb.imm_hi[6], ir_q.sb.imm_lo[0],
                    ir_q.sb.imm_hi[5:0], ir_q.sb.imm_lo[4:1], 1'b0};

    assign halted_o    = halted_q;
    assign bus_cyc_o   = req_q;
    assign bus_stb_o   = req_q;
    assign bus_we_o    = (state_q == S_MEM) && mem_we_q;
    assign bus_addr_o  = (state_q == S_MEM) ? maddr_q : pc_q;
    assign bus_wdata_o = sdata_q;

    always_ff @(posedge sys_clk_i) begin
        if (reset_i || !core_run_i) begin    // Held core restarts clean
            state_q  <= S_FETCH;
            pc_q     <= '0;
            req_q    <= 1'b0;
            mem_we_q <= 1'b0;
            halted_q <= 1'b0;
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else begin
            case (state_q)
                S_FETCH: begin
                    if (bus_ack_i) begin
                        ir_q    <= bus_rdata_i;
                        req_q   <= 1'b0;
                        state_q <= S_EXEC;
                    end else begin
                        req_q <= 1'b1;
                    end
                end
                S_EXEC: begin
                    state_q <= S_FETCH;
                    req_q   <= 1'b1;
                    pc_q    <= pc_q + 32'd4;
                    case (ir_q.ri.opcode)
                        OP_REG: if (rd_nz)    // funct7[5] picks SUB
                            regs[ir_q.ri.rd] <= ir_q.ri.funct7[5] ? rs1_val - rs2_val
                                                                  : rs1_val + rs2_val;
                        OP_IMM: if (rd_nz)
                            regs[ir_q.ri.rd] <= rs1_val + imm_i;
                        OP_LOAD: begin
                            maddr_q  <= rs1_val + imm_i;
                            mem_we_q <= 1'b0;
                            state_q  <= S_MEM;
                        end
                        OP_STORE: begin
                            maddr_q  <= rs1_val + imm_s;
                            sdata_q  <= rs2_val;
                            mem_we_q <= 1'b1;
                            state_q  <= S_MEM;
                        end
                        OP_BRANCH: if (rs1_val == rs2_val)
                            pc_q <= pc_q + imm_b;
                        OP_SYSTEM: begin    // ECALL
                            halted_q <= 1'b1;
                            req_q    <= 1'b0;
                            state_q  <= S_HALT;
                        end
                        default: ;    // Unknown opcode acts as a no-op
                    endcase
                end
                S_MEM: if (bus_ack_i) begin
                    if (!mem_we_q && rd_nz)
                        regs[ir_q.ri.rd] <= bus_rdata_i;
                    state_q <= S_FETCH;    // Request stays up for the next fetch
                end
                default: ;    // Stay halted until run drops
            endcase
        end
    end

endmodule

/* shared_wb_mem.sv */
`timescale 1ns/1ns

module shared_wb_mem #(
    parameter int MEM_WORDS = 256
) (
    input  logic                              sys_clk_i,
    input  logic                              reset_i,
    input  logic                              a_cyc_i,
    input  logic                              a_stb_i,
    input  logic                              a_we_i,
    input  logic [proc_ci_pkg::BUS_WIDTH-1:0] a_addr_i,
    input  logic [proc_ci_pkg::BUS_WIDTH-1:0] a_wdata_i,
    output logic [proc_ci_pkg::BUS_WIDTH-1:0] a_rdata_o,
    output logic                              a_ack_o,
    input  logic                              b_cyc_i,
    input  logic                              b_stb_i,
    input  logic                              b_we_i,
    input  logic [proc_ci_pkg::BUS_WIDTH-1:0] b_addr_i,
    input  logic [proc_ci_pkg::BUS_WIDTH-1:0] b_wdata_i,
    output logic [proc_ci_pkg::BUS_WIDTH-1:0] b_rdata_o,
    output logic                              b_ack_o
);
    import proc_ci_pkg::*;

    localparam int IW = $clog2(MEM_WORDS);

    logic [BUS_WIDTH-1:0] mem [MEM_WORDS];
    logic [BUS_WIDTH-1:0] rdata_q;
    logic [IW-1:0]        idx;
    logic                 grant_a;
    logic                 grant_b;

    // No regrant in the ack cycle, the master is still dropping stb
    assign grant_a = a_cyc_i && a_stb_i && !a_ack_o;
    assign grant_b = b_cyc_i && b_stb_i && !b_ack_o && !grant_a;    // Controller first

    assign idx = grant_a ? a_addr_i[IW+1:2] : b_addr_i[IW+1:2];    // Wraps at MEM_WORDS

    assign a_rdata_o = rdata_q;
    assign b_rdata_o = rdata_q;

    always_ff @(posedge sys_clk_i) begin
        if (grant_a || grant_b) begin
            if (grant_a ? a_we_i : b_we_i)
                mem[idx] <= grant_a ? a_wdata_i : b_wdata_i;
            rdata_q <= mem[idx];
        end
    end

    always_ff @(posedge sys_clk_i) begin
        if (reset_i) begin
            a_ack_o <= 1'b0;
            b_ack_o <= 1'b0;
        end else begin
            a_ack_o <= grant_a;
            b_ack_o <= grant_b;
        end
    end

endmodule

/* proc_ci_top.sv */
`timescale 1ns/1ns

module proc_ci_top #(
    parameter int CLKS_PER_BIT = 16,
    parameter int MEM_WORDS    = 256
) (
    input  logic sys_clk_i,
    input  logic reset_i,
    input  logic rx_i,
    output logic tx_o
);
    import proc_ci_pkg::*;

    logic [7:0] rx_data;
    logic       rx_valid;
    logic [7:0] tx_data;
    logic       tx_start;
    logic       tx_busy;
    logic       core_run;
    logic       halted;

    // Controller side of the memory
    logic                 ctl_cyc;
    logic                 ctl_stb;
    logic                 ctl_we;
    logic [BUS_WIDTH-1:0] ctl_addr;
    logic [BUS_WIDTH-1:0] ctl_wdata;
    logic [BUS_WIDTH-1:0] ctl_rdata;
    logic                 ctl_ack;

    // Core side of the memory
    logic                 core_cyc;
    logic                 core_stb;
    logic                 core_we;
    logic [BUS_WIDTH-1:0] core_addr;
    logic [BUS_WIDTH-1:0] core_wdata;
    logic [BUS_WIDTH-1:0] core_rdata;
    logic                 core_ack;

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_rx_i (
        .sys_clk_i  (sys_clk_i),
        .reset_i    (reset_i),
        .rx_i       (rx_i),
        .rx_data_o  (rx_data),
        .rx_valid_o (rx_valid)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_tx_i (
        .sys_clk_i  (sys_clk_i),
        .reset_i    (reset_i),
        .tx_data_i  (tx_data),
        .tx_start_i (tx_start),
        .tx_o       (tx_o),
        .tx_busy_o  (tx_busy)
    );

    host_cmd_ctrl host_cmd_ctrl_i (
        .sys_clk_i     (sys_clk_i),
        .reset_i       (reset_i),
        .rx_data_i     (rx_data),
        .rx_valid_i    (rx_valid),
        .tx_data_o     (tx_data),
        .tx_start_o    (tx_start),
        .tx_busy_i     (tx_busy),
        .bus_cyc_o     (ctl_cyc),
        .bus_stb_o     (ctl_stb),
        .bus_we_o      (ctl_we),
        .bus_addr_o    (ctl_addr),
        .bus_wdata_o   (ctl_wdata),
        .bus_rdata_i   (ctl_rdata),
        .bus_ack_i     (ctl_ack),
        .core_run_o    (core_run),
        .core_halted_i (halted)
    );

    rv_mini_core rv_mini_core_i (
        .sys_clk_i   (sys_clk_i),
        .reset_i     (reset_i),
        .core_run_i  (core_run),
        .halted_o    (halted),
        .bus_cyc_o   (core_cyc),
        .bus_stb_o   (core_stb),
        .bus_we_o    (core_we),
        .bus_addr_o  (core_addr),
        .bus_wdata_o (core_wdata),
        .bus_rdata_i (core_rdata),
        .bus_ack_i   (core_ack)
    );

    shared_wb_mem #(.MEM_WORDS(MEM_WORDS)) shared_wb_mem_i (
        .sys_clk_i (sys_clk_i),
        .reset_i   (reset_i),
        .a_cyc_i   (ctl_cyc),
        .a_stb_i   (ctl_stb),
        .a_we_i    (ctl_we),
        .a_addr_i  (ctl_addr),
        .a_wdata_i (ctl_wdata),
        .a_rdata_o (ctl_rdata),
        .a_ack_o   (ctl_ack),
        .b_cyc_i   (core_cyc),
        .b_stb_i   (core_stb),
        .b_we_i    (core_we),
        .b_addr_i  (core_addr),
        .b_wdata_i (core_wdata),
        .b_rdata_o (core_rdata),
        .b_ack_o   (core_ack)
    );

endmodule

/* tb_proc_ci.sv */
`timescale 1ns/1ns

module tb_proc_ci;
    import proc_ci_pkg::*;

    localparam int BIT_CLKS   = 4;
    localparam int RX_TIMEOUT = 20000;    // Cycles to wait for a reply start bit
    localparam int LOOP_N     = 5;        // Countdown length in the program

    logic sys_clk;
    logic reset;
    logic rx;
    logic tx;

    integer      seed;
    int          err_cnt;
    int          err_mark;
    int          pass_cnt;
    int          fail_cnt;
    string       cur_test;
    logic [31:0] exp_mem [256];    // Last value written per index
    logic [7:0]  idx_list [10];

    proc_ci_top #(.CLKS_PER_BIT(BIT_CLKS), .MEM_WORDS(256)) proc_ci_top_i (
        .sys_clk_i (sys_clk),
        .reset_i   (reset),
        .rx_i      (rx),
        .tx_o      (tx)
    );

    always #20 sys_clk = ~sys_clk;

    // Instruction encoders
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
            input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [6:0] op);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [6:0] op);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op};
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
        assert (got === exp) else begin
            $display("FAILED at %0t ns: %s, got %h, expected %h", $time, msg, got, exp);
            err_cnt++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        err_mark = err_cnt;
    endtask

    task automatic end_test();
        if (err_cnt == err_mark) begin
            pass_cnt++;
            $display("test %s: ok", cur_test);
        end else begin
            fail_cnt++;
            $display("test %s: %0d error(s)", cur_test, err_cnt - err_mark);
        end
    endtask

    task automatic report_and_finish();
        $display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    endtask

    // Host side 8N1 frame, LSB first
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        @(posedge sys_clk);
        #2;
        for (int i = 0; i < 10; i++) begin
            rx = frame[i];
            repeat (BIT_CLKS) @(posedge sys_clk);
            #2;
        end
    endtask

    task automatic recv_byte(output logic [7:0] b, input string what);
        int waited;
        waited = 0;
        b = '0;
        @(negedge sys_clk);
        while (tx !== 1'b0 && waited < RX_TIMEOUT) begin
            @(negedge sys_clk);
            waited++;
        end
        if (tx !== 1'b0) begin
            $display("TIMEOUT: the %s reply never arrived", what);
            fail_cnt++;
            report_and_finish();
        end else begin
            repeat (BIT_CLKS / 2) @(negedge sys_clk);    // Middle of the start bit
            check_eq(tx, 1'b0, {"start bit of ", what, " reply"});
            for (int i = 0; i < 8; i++) begin
                repeat (BIT_CLKS) @(negedge sys_clk);
                b[i] = tx;
            end
            repeat (BIT_CLKS) @(negedge sys_clk);
            check_eq(tx, 1'b1, {"stop bit of ", what, " reply"});
        end
    endtask

    task automatic write_word(input logic [7:0] idx, input logic [31:0] data);
        logic [7:0] rsp;
        send_byte(CMD_WRITE);
        send_byte(idx);
        for (int i = 0; i < 4; i++)
            send_byte(data[8*i +: 8]);
        recv_byte(rsp, "WRITE");
        check_eq(rsp, RSP_OK, $sformatf("WRITE reply for index %0d", idx));
        exp_mem[idx] = data;
    endtask

    task automatic read_word(input logic [7:0] idx, output logic [31:0] data);
        logic [7:0] b;
        send_byte(CMD_READ);
        send_byte(idx);
        for (int i = 0; i < 4; i++) begin
            recv_byte(b, "READ");
            data[8*i +: 8] = b;
        end
    endtask

    task automatic load_program();
        logic [31:0] prog [13];
        int          k;
        prog[0]  = i_type(12'd256, 5'd0, 3'b010, 5'd1, OP_LOAD);       // lw x1, 256(x0)
        prog[1]  = i_type(12'd260, 5'd0, 3'b010, 5'd2, OP_LOAD);       // lw x2, 260(x0)
        prog[2]  = r_type(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd3, OP_REG);
        prog[3]  = r_type(7'b0100000, 5'd2, 5'd1, 3'b000, 5'd4, OP_REG);    // sub
        prog[4]  = i_type(12'(LOOP_N), 5'd0, 3'b000, 5'd5, OP_IMM);
        // Loop head, exits to the stores when x5 hits zero
        prog[5]  = b_type(13'd16, 5'd0, 5'd5, 3'b000, OP_BRANCH);
        prog[6]  = r_type(7'b0000000, 5'd1, 5'd6, 3'b000, 5'd6, OP_REG);    // x6 += x1
        prog[7]  = i_type(12'hFFF, 5'd5, 3'b000, 5'd5, OP_IMM);        // x5 -= 1
        prog[8]  = b_type(13'h1FF4, 5'd0, 5'd0, 3'b000, OP_BRANCH);   // Back by 12
        prog[9]  = s_type(12'd264, 5'd3, 5'd0, 3'b010, OP_STORE);
        prog[10] = s_type(12'd268, 5'd4, 5'd0, 3'b010, OP_STORE);
        prog[11] = s_type(12'd272, 5'd6, 5'd0, 3'b010, OP_STORE);
        prog[12] = {25'd0, OP_SYSTEM};                                 // ecall
        for (k = 0; k < 13; k++)
            write_word(8'(k), prog[k]);
    endtask

    task automatic run_and_check(input logic [31:0] a, input logic [31:0] b);
        logic [7:0]  rsp;
        logic [31:0] got;
        logic [31:0] exp_res [3];
        exp_res[0] = a + b;
        exp_res[1] = a - b;
        exp_res[2] = a * LOOP_N;
        write_word(8'd64, a);
        write_word(8'd65, b);
        for (int k = 0; k < 3; k++)
            write_word(8'(66 + k), 32'hBAD0_0000 | k);    // Stale markers
        send_byte(CMD_RUN);
        recv_byte(rsp, "RUN");
        check_eq(rsp, RSP_DONE, "RUN reply");
        for (int k = 0; k < 3; k++) begin
            read_word(8'(66 + k), got);
            check_eq(got, exp_res[k], $sformatf("result at index %0d", 66 + k));
        end
    endtask

    initial begin
        logic [7:0]  rsp;
        logic [31:0] got;
        logic [31:0] data;
        sys_clk  = 1'b0;
        reset    = 1'b1;
        rx       = 1'b1;
        seed     = 85814;
        err_cnt  = 0;
        pass_cnt = 0;
        fail_cnt = 0;

        start_test("reset_idle");
        repeat (4) begin
            @(posedge sys_clk);
            #1;
            check_eq(tx, 1'b1, "tx_o during reset");
        end
        #1 reset = 1'b0;
        repeat (8) begin
            @(negedge sys_clk);
            check_eq(tx, 1'b1, "tx_o idle before first command");
        end
        end_test();

        start_test("write_read_random");
        for (int k = 0; k < 10; k++) begin
            idx_list[k] = 8'($random(seed));
            data        = $random(seed);
            write_word(idx_list[k], data);
        end
        for (int k = 0; k < 10; k++) begin
            read_word(idx_list[k], got);
            check_eq(got, exp_mem[idx_list[k]], $sformatf("READ of index %0d", idx_list[k]));
        end
        end_test();

        start_test("unknown_opcode");
        send_byte(8'h7F);
        recv_byte(rsp, "unknown opcode");
        check_eq(rsp, RSP_BAD, "unknown opcode reply");
        read_word(idx_list[0], got);
        check_eq(got, exp_mem[idx_list[0]], "READ after unknown opcode");
        end_test();

        start_test("program_run");
        load_program();
        run_and_check($random(seed), $random(seed));
        end_test();

        start_test("halt_and_rerun");
        send_byte(CMD_HALT_CORE);
        recv_byte(rsp, "HALT_CORE");
        check_eq(rsp, RSP_OK, "HALT_CORE reply");
        run_and_check($random(seed), $random(seed));
        end_test();

        report_and_finish();
    end

endmodule

/* vlog.f */
proc_ci_pkg.sv
uart_rx.sv
uart_tx.sv
host_cmd_ctrl.sv
rv_mini_core.sv
shared_wb_mem.sv
proc_ci_top.sv
tb_proc_ci.sv
